// File: rtl/i3c_target_pkg.sv
// Shared types and constants for the I3C/I2C target receive front end.
// Referenced by scoped name from the RTL and the testbench.

`default_nettype none

package i3c_target_pkg;

  // Result of matching a received address against the configured ones
  typedef enum logic [1:0] {
    ADDR_NONE      = 2'd0,
    ADDR_STATIC    = 2'd1,
    ADDR_DYNAMIC   = 2'd2,
    ADDR_BROADCAST = 2'd3
  } addr_kind_e;

  // Address receiver FSM
  typedef enum logic {
    RX_IDLE = 1'b0,
    RX_ADDR = 1'b1
  } rx_state_e;

  // APB register byte offsets
  localparam logic [7:0] REG_CTRL         = 8'h00;
  localparam logic [7:0] REG_STATIC_ADDR  = 8'h04;
  localparam logic [7:0] REG_DYNAMIC_ADDR = 8'h08;
  localparam logic [7:0] REG_STATUS       = 8'h0C;

  // Field positions inside the registers
  localparam int unsigned CTRL_EN_BIT    = 0;
  localparam int unsigned ADDR_VALID_BIT = 31;

  // I3C broadcast address, always accepted
  localparam logic [6:0] BROADCAST_ADDR = 7'h7E;

endpackage

`default_nettype wire

// File: rtl/bus_event_if.sv
// Synchronized bus conditions from the bus monitor to the address receiver.
// All event fields are single-cycle pulses aligned with the sda level.

`default_nettype none

interface bus_event_if;

  logic start;
  logic rstart;
  logic stop;
  logic scl_rise;
  // Synchronized SDA, aligned with the pulses
  logic sda;

  modport mon (
    output start, rstart, stop, scl_rise, sda
  );

  modport rcv (
    input start, rstart, stop, scl_rise, sda
  );

endinterface

`default_nettype wire

// File: rtl/addr_cfg_if.sv
// Configured target addresses from the register block to the address receiver.
// Values are static levels held by the registers.

`default_nettype none

interface addr_cfg_if;

  logic [6:0] sta_addr;
  logic       sta_valid;
  logic [6:0] dyn_addr;
  logic       dyn_valid;

  modport regs (
    output sta_addr, sta_valid, dyn_addr, dyn_valid
  );

  modport rcv (
    input sta_addr, sta_valid, dyn_addr, dyn_valid
  );

endinterface

`default_nettype wire

// File: rtl/target_regs.sv
// APB register block of the target front end.
// Holds enable, static and dynamic address, and the last captured address byte.
// Zero wait states; writes and read data take effect in the access cycle.

`default_nettype none

module target_regs #(
  parameter int unsigned ApbAddrWidth = 8
) (
  input  wire                    clk_i,
  input  wire                    rst_n_i,

  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire [ApbAddrWidth-1:0] paddr_i,
  input  wire [31:0]             pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,

  addr_cfg_if.regs               cfg,
  output logic                   enable_o,

  input  wire [7:0]              last_addr_i,
  input  wire                    last_addr_we_i
);

  localparam logic [ApbAddrWidth-1:0] OffCtrl   = ApbAddrWidth'(i3c_target_pkg::REG_CTRL);
  localparam logic [ApbAddrWidth-1:0] OffStatic =
    ApbAddrWidth'(i3c_target_pkg::REG_STATIC_ADDR);
  localparam logic [ApbAddrWidth-1:0] OffDynamic =
    ApbAddrWidth'(i3c_target_pkg::REG_DYNAMIC_ADDR);
  localparam logic [ApbAddrWidth-1:0] OffStatus = ApbAddrWidth'(i3c_target_pkg::REG_STATUS);

  logic       access;
  logic       wr_en;
  logic       sel_ctrl;
  logic       sel_sta;
  logic       sel_dyn;
  logic       sel_status;
  logic       mapped;

  logic       ctrl_en_q;
  logic [6:0] sta_addr_q;
  logic       sta_valid_q;
  logic [6:0] dyn_addr_q;
  logic       dyn_valid_q;
  logic [7:0] status_q;

  assign access     = psel_i & penable_i;
  assign wr_en      = access & pwrite_i;

  assign sel_ctrl   = (paddr_i == OffCtrl);
  assign sel_sta    = (paddr_i == OffStatic);
  assign sel_dyn    = (paddr_i == OffDynamic);
  assign sel_status = (paddr_i == OffStatus);
  assign mapped     = sel_ctrl | sel_sta | sel_dyn | sel_status;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_en_q   <= 1'b0;
      sta_addr_q  <= '0;
      sta_valid_q <= 1'b0;
      dyn_addr_q  <= '0;
      dyn_valid_q <= 1'b0;
      status_q    <= '0;
    end else begin
      if (wr_en && sel_ctrl) begin
        ctrl_en_q <= pwdata_i[i3c_target_pkg::CTRL_EN_BIT];
      end
      if (wr_en && sel_sta) begin
        sta_addr_q  <= pwdata_i[6:0];
        sta_valid_q <= pwdata_i[i3c_target_pkg::ADDR_VALID_BIT];
      end
      if (wr_en && sel_dyn) begin
        dyn_addr_q  <= pwdata_i[6:0];
        dyn_valid_q <= pwdata_i[i3c_target_pkg::ADDR_VALID_BIT];
      end
      // Status is hardware-owned
      if (last_addr_we_i) begin
        status_q <= last_addr_i;
      end
    end
  end

  always_comb begin
    prdata_o = '0;
    if (sel_ctrl) begin
      prdata_o[i3c_target_pkg::CTRL_EN_BIT] = ctrl_en_q;
    end else if (sel_sta) begin
      prdata_o[6:0]                            = sta_addr_q;
      prdata_o[i3c_target_pkg::ADDR_VALID_BIT] = sta_valid_q;
    end else if (sel_dyn) begin
      prdata_o[6:0]                            = dyn_addr_q;
      prdata_o[i3c_target_pkg::ADDR_VALID_BIT] = dyn_valid_q;
    end else if (sel_status) begin
      prdata_o[7:0] = status_q;
    end
  end

  assign pready_o  = 1'b1;
  // Unmapped offsets and status writes are errors
  assign pslverr_o = access & (~mapped | (pwrite_i & sel_status));

  assign enable_o      = ctrl_en_q;
  assign cfg.sta_addr  = sta_addr_q;
  assign cfg.sta_valid = sta_valid_q;
  assign cfg.dyn_addr  = dyn_addr_q;
  assign cfg.dyn_valid = dyn_valid_q;

endmodule

`default_nettype wire

// File: rtl/bus_monitor.sv
// Synchronizes SCL/SDA and detects START, repeated START, STOP and SCL rise.
// Event pulses are registered and last one clock cycle.

`default_nettype none

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  wire      clk_i,
  input  wire      rst_n_i,
  input  wire      enable_i,
  input  wire      scl_i,
  input  wire      sda_i,
  bus_event_if.mon ev,
  output logic     bus_start_o,
  output logic     bus_rstart_o,
  output logic     bus_stop_o
);

  // Top bit is the previous synchronized sample
  logic [SyncStages:0] scl_pipe_q;
  logic [SyncStages:0] sda_pipe_q;

  logic scl_s;
  logic scl_prev;
  logic sda_s;
  logic sda_prev;
  logic start_cond;
  logic stop_cond;
  logic scl_rise;

  logic xfer_open_q;
  logic start_q;
  logic rstart_q;
  logic stop_q;
  logic scl_rise_q;

  // Idle bus is high, so reset to ones to avoid false edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_pipe_q <= '1;
      sda_pipe_q <= '1;
    end else begin
      scl_pipe_q <= {scl_pipe_q[SyncStages-1:0], scl_i};
      sda_pipe_q <= {sda_pipe_q[SyncStages-1:0], sda_i};
    end
  end

  assign scl_s    = scl_pipe_q[SyncStages-1];
  assign scl_prev = scl_pipe_q[SyncStages];
  assign sda_s    = sda_pipe_q[SyncStages-1];
  assign sda_prev = sda_pipe_q[SyncStages];

  // SDA edges only count while SCL stays high
  assign start_cond = enable_i & scl_s & scl_prev & sda_prev & ~sda_s;
  assign stop_cond  = enable_i & scl_s & scl_prev & ~sda_prev & sda_s;
  assign scl_rise   = enable_i & ~scl_prev & scl_s;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      xfer_open_q <= 1'b0;
      start_q     <= 1'b0;
      rstart_q    <= 1'b0;
      stop_q      <= 1'b0;
      scl_rise_q  <= 1'b0;
    end else begin
      start_q    <= start_cond & ~xfer_open_q;
      rstart_q   <= start_cond & xfer_open_q;
      stop_q     <= stop_cond;
      scl_rise_q <= scl_rise;
      if (!enable_i || stop_cond) begin
        xfer_open_q <= 1'b0;
      end else if (start_cond) begin
        xfer_open_q <= 1'b1;
      end
    end
  end

  assign ev.start    = start_q;
  assign ev.rstart   = rstart_q;
  assign ev.stop     = stop_q;
  assign ev.scl_rise = scl_rise_q;
  // One stage later than sda_s, lines up with the registered pulses
  assign ev.sda      = sda_prev;

  assign bus_start_o  = start_q;
  assign bus_rstart_o = rstart_q;
  assign bus_stop_o   = stop_q;

endmodule

`default_nettype wire

// File: rtl/addr_receiver.sv
// Shifts in the first byte after a START or repeated START, MSB first.
// Reports the byte with RnW and classifies it against the configured addresses.
// Result is valid for one cycle after the eighth SCL rise.

`default_nettype none

module addr_receiver (
  input  wire                        clk_i,
  input  wire                        rst_n_i,
  bus_event_if.rcv                   ev,
  addr_cfg_if.rcv                    cfg,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o,
  output i3c_target_pkg::addr_kind_e addr_kind_o,
  output logic                       addr_hit_o
);

  i3c_target_pkg::rx_state_e  state_q;
  logic [2:0]                 bit_cnt_q;
  logic [6:0]                 shift_q;
  logic [7:0]                 byte_d;
  logic [6:0]                 addr_d;
  i3c_target_pkg::addr_kind_e kind_d;

  // Byte as it would be after taking the current bit
  assign byte_d = {shift_q, ev.sda};
  assign addr_d = byte_d[7:1];

  // Broadcast first, then dynamic; static only until a dynamic address is assigned
  always_comb begin
    if (addr_d == i3c_target_pkg::BROADCAST_ADDR) begin
      kind_d = i3c_target_pkg::ADDR_BROADCAST;
    end else if (cfg.dyn_valid && (addr_d == cfg.dyn_addr)) begin
      kind_d = i3c_target_pkg::ADDR_DYNAMIC;
    end else if (cfg.sta_valid && !cfg.dyn_valid && (addr_d == cfg.sta_addr)) begin
      kind_d = i3c_target_pkg::ADDR_STATIC;
    end else begin
      kind_d = i3c_target_pkg::ADDR_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == i3c_target_pkg::RX_ADDR) && ev.scl_rise) begin
      shift_q <= byte_d[6:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= i3c_target_pkg::RX_IDLE;
      bit_cnt_q        <= '0;
      bus_addr_valid_o <= 1'b0;
      bus_addr_o       <= '0;
      addr_kind_o      <= i3c_target_pkg::ADDR_NONE;
    end else begin
      bus_addr_valid_o <= 1'b0;
      if (ev.start || ev.rstart) begin
        state_q   <= i3c_target_pkg::RX_ADDR;
        bit_cnt_q <= '0;
      end else if (ev.stop) begin
        // Abandon a partial byte
        state_q <= i3c_target_pkg::RX_IDLE;
      end else if ((state_q == i3c_target_pkg::RX_ADDR) && ev.scl_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
        if (bit_cnt_q == 3'd7) begin
          state_q          <= i3c_target_pkg::RX_IDLE;
          bus_addr_valid_o <= 1'b1;
          bus_addr_o       <= byte_d;
          addr_kind_o      <= kind_d;
        end
      end
    end
  end

  assign addr_hit_o = (addr_kind_o != i3c_target_pkg::ADDR_NONE);

endmodule

`default_nettype wire

// File: rtl/i3c_target_front.sv
// Receive front end of an I3C/I2C target that only observes the bus.
// Pipeline: bus monitor, address receiver, APB register block.
// Bus events appear SyncStages+1 cycles after the bus edge.

`default_nettype none

module i3c_target_front #(
  parameter int unsigned ApbAddrWidth = 8,
  parameter int unsigned SyncStages   = 2
) (
  input  wire                        clk_i,
  input  wire                        rst_n_i,

  // APB slave
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire [ApbAddrWidth-1:0]     paddr_i,
  input  wire [31:0]                 pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,

  // I2C/I3C bus, observed only
  input  wire                        scl_i,
  input  wire                        sda_i,

  output logic                       bus_start_o,
  output logic                       bus_rstart_o,
  output logic                       bus_stop_o,
  output logic [7:0]                 bus_addr_o,
  output logic                       bus_addr_valid_o,
  output i3c_target_pkg::addr_kind_e addr_kind_o,
  output logic                       addr_hit_o
);

  logic target_en;

  bus_event_if bus_ev ();
  addr_cfg_if  addr_cfg ();

  target_regs #(
    .ApbAddrWidth (ApbAddrWidth)
  ) u_target_regs (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .paddr_i        (paddr_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .cfg            (addr_cfg.regs),
    .enable_o       (target_en),
    .last_addr_i    (bus_addr_o),
    .last_addr_we_i (bus_addr_valid_o)
  );

  bus_monitor #(
    .SyncStages (SyncStages)
  ) u_bus_monitor (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .enable_i     (target_en),
    .scl_i        (scl_i),
    .sda_i        (sda_i),
    .ev           (bus_ev.mon),
    .bus_start_o  (bus_start_o),
    .bus_rstart_o (bus_rstart_o),
    .bus_stop_o   (bus_stop_o)
  );

  addr_receiver u_addr_receiver (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .ev               (bus_ev.rcv),
    .cfg              (addr_cfg.rcv),
    .bus_addr_o       (bus_addr_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .addr_kind_o      (addr_kind_o),
    .addr_hit_o       (addr_hit_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_clk_gen.sv
// Clock and reset source for the testbench.
// Period of 20 time units, reset held low for the first four cycles.

`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release on a falling edge, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/tb_i3c_target_front.sv
// Directed testbench for the target receive front end.
// Drives APB accesses and SCL/SDA sequences on the falling edge and checks
// bus events, address capture, REG_STATUS and match classification.

`default_nettype none

module tb_i3c_target_front;

  localparam int Timeout = 200;

  logic        clk, rst_n;
  logic        psel, penable, pwrite, pready, pslverr;
  logic [7:0]  paddr;
  logic [31:0] pwdata, prdata;
  logic        scl, sda;
  logic        bus_start, bus_rstart, bus_stop, bus_addr_valid, addr_hit;
  logic [7:0]  bus_addr;
  i3c_target_pkg::addr_kind_e addr_kind, last_kind;
  logic [7:0]  last_addr;
  logic        last_hit;
  logic [6:0]  sta;
  logic [6:0]  dyn;
  logic [31:0] lfsr = 32'h84a3_6258;
  logic        bus_en = 1'b0;
  logic        xfer_open = 1'b0;
  int start_cnt = 0, rstart_cnt = 0, stop_cnt = 0, addr_cnt = 0;
  int exp_start = 0, exp_rstart = 0, exp_stop = 0, exp_addr = 0;

  tb_clk_gen u_tb_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  i3c_target_front #(
    .ApbAddrWidth (8),
    .SyncStages   (2)
  ) u_i3c_target_front (
    .clk_i (clk), .rst_n_i (rst_n),
    .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite), .paddr_i (paddr),
    .pwdata_i (pwdata), .prdata_o (prdata), .pready_o (pready), .pslverr_o (pslverr),
    .scl_i (scl), .sda_i (sda),
    .bus_start_o (bus_start), .bus_rstart_o (bus_rstart), .bus_stop_o (bus_stop),
    .bus_addr_o (bus_addr), .bus_addr_valid_o (bus_addr_valid),
    .addr_kind_o (addr_kind), .addr_hit_o (addr_hit)
  );

  // Count each pulse at the edge that ends its cycle
  always @(posedge clk) begin
    if (bus_start) start_cnt <= start_cnt + 1;
    if (bus_rstart) rstart_cnt <= rstart_cnt + 1;
    if (bus_stop) stop_cnt <= stop_cnt + 1;
    if (bus_addr_valid) begin
      addr_cnt  <= addr_cnt + 1;
      last_addr <= bus_addr;
      last_kind <= addr_kind;
      last_hit  <= addr_hit;
    end
  end

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("Error: time %0t signal %s got 0x%0h expected 0x%0h",
                          $time, name, got, exp));
    end
  endtask

  // Right-shifting Galois LFSR
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_addr(output logic [6:0] a);
    a = '0;
    for (int i = 0; i < 7; i++) begin
      lfsr = lfsr_step(lfsr);
      a = {a[5:0], lfsr[0]};
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                          input logic exp_err);
    int n;
    n = 0;
    @(negedge clk);
    psel    = 1'b1;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wr ? data : 32'h0;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    while (!pready) begin
      if (n == Timeout) fail_stop("APB transfer never completed, pready stayed low");
      n++;
      @(posedge clk);
    end
    check_value("pslverr_o", 32'(pslverr), 32'(exp_err));
    if (!wr) check_value("prdata_o", prdata, data);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_enable(input logic en);
    apb_xfer(1'b1, i3c_target_pkg::REG_CTRL, 32'(en), 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_CTRL, 32'(en), 1'b0);
    bus_en = en;
    xfer_open = xfer_open & en;
  endtask

  // Wait until every pulse count matches what the bus activity should have produced
  task automatic wait_bus();
    int n;
    n = 0;
    while ({start_cnt, rstart_cnt, stop_cnt, addr_cnt} !=
           {exp_start, exp_rstart, exp_stop, exp_addr}) begin
      if (n == Timeout) fail_stop("Bus event pulses did not match the bus activity");
      n++;
      @(negedge clk);
    end
  endtask

  // Each level is held for 4 clock cycles
  task automatic drive_bus(input logic scl_v, input logic sda_v);
    @(negedge clk);
    scl = scl_v;
    sda = sda_v;
    repeat (3) @(negedge clk);
  endtask

  task automatic send_start();
    drive_bus(1'b0, 1'b1);
    drive_bus(1'b1, 1'b1);
    drive_bus(1'b1, 1'b0);
    drive_bus(1'b0, 1'b0);
    if (bus_en && xfer_open) exp_rstart++;
    else if (bus_en) exp_start++;
    xfer_open = bus_en;
    wait_bus();
  endtask

  task automatic send_stop();
    drive_bus(1'b0, 1'b0);
    drive_bus(1'b1, 1'b0);
    drive_bus(1'b1, 1'b1);
    if (bus_en) exp_stop++;
    xfer_open = 1'b0;
    wait_bus();
  endtask

  task automatic send_addr(input logic [6:0] a, input logic rnw,
                           input i3c_target_pkg::addr_kind_e exp_kind);
    logic [7:0] b;
    b = {a, rnw};
    send_start();
    for (int i = 7; i >= 0; i--) begin
      drive_bus(1'b0, b[i]);
      drive_bus(1'b1, b[i]);
    end
    exp_addr++;
    wait_bus();
    check_value("bus_addr_o", 32'(last_addr), 32'(b));
    check_value("addr_kind_o", 32'(last_kind), 32'(exp_kind));
    check_value("addr_hit_o", 32'(last_hit), 32'(exp_kind != i3c_target_pkg::ADDR_NONE));
    send_stop();
    apb_xfer(1'b0, i3c_target_pkg::REG_STATUS, 32'(b), 1'b0);
  endtask

  // Registers read zero and no pulse has been seen
  task automatic verify_reset_state();
    apb_xfer(1'b0, i3c_target_pkg::REG_CTRL, 32'h0, 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_STATIC_ADDR, 32'h0, 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_DYNAMIC_ADDR, 32'h0, 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_STATUS, 32'h0, 1'b0);
    wait_bus();
    check_value("addr_kind_o", 32'(addr_kind), 32'(i3c_target_pkg::ADDR_NONE));
  endtask

  // Addresses kept apart from each other and from broadcast
  task automatic exercise_apb_regs();
    rand_addr(sta);
    rand_addr(dyn);
    if (sta == i3c_target_pkg::BROADCAST_ADDR) sta = sta ^ 7'h01;
    while (dyn == sta || dyn == i3c_target_pkg::BROADCAST_ADDR) dyn = dyn + 7'd1;
    set_enable(1'b1);
    apb_xfer(1'b1, i3c_target_pkg::REG_STATIC_ADDR, {1'b1, 24'h0, sta}, 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_STATIC_ADDR, {1'b1, 24'h0, sta}, 1'b0);
    apb_xfer(1'b1, i3c_target_pkg::REG_DYNAMIC_ADDR, {1'b0, 24'h0, dyn}, 1'b0);
    apb_xfer(1'b0, i3c_target_pkg::REG_DYNAMIC_ADDR, {1'b0, 24'h0, dyn}, 1'b0);
    apb_xfer(1'b1, 8'h10, 32'hFFFF_FFFF, 1'b1);
    apb_xfer(1'b0, 8'h10, 32'h0, 1'b1);
    apb_xfer(1'b1, i3c_target_pkg::REG_STATUS, 32'h55, 1'b1);
    apb_xfer(1'b0, i3c_target_pkg::REG_STATUS, 32'h0, 1'b0);
  endtask

  // START, repeated START, STOP, then the same with the target disabled
  task automatic exercise_bus_conditions();
    send_start();
    send_start();
    send_stop();
    set_enable(1'b0);
    send_start();
    send_stop();
    repeat (8) @(negedge clk);
    wait_bus();
    set_enable(1'b1);
  endtask

  task automatic classify_addresses();
    logic [6:0] other;
    send_addr(sta, 1'b0, i3c_target_pkg::ADDR_STATIC);
    send_addr(dyn, 1'b1, i3c_target_pkg::ADDR_NONE);
    apb_xfer(1'b1, i3c_target_pkg::REG_DYNAMIC_ADDR, {1'b1, 24'h0, dyn}, 1'b0);
    send_addr(dyn, 1'b0, i3c_target_pkg::ADDR_DYNAMIC);
    send_addr(sta, 1'b1, i3c_target_pkg::ADDR_NONE);
    send_addr(i3c_target_pkg::BROADCAST_ADDR, 1'b0, i3c_target_pkg::ADDR_BROADCAST);
    rand_addr(other);
    while (other == sta || other == dyn || other == i3c_target_pkg::BROADCAST_ADDR) begin
      other = other + 7'd1;
    end
    send_addr(other, 1'b1, i3c_target_pkg::ADDR_NONE);
  endtask

  initial begin
    int n;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    scl     = 1'b1;
    sda     = 1'b1;
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == Timeout) fail_stop("Reset was never released");
      n++;
      @(negedge clk);
    end

    verify_reset_state();
    exercise_apb_regs();
    exercise_bus_conditions();
    classify_addresses();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
rtl/i3c_target_pkg.sv
rtl/bus_event_if.sv
rtl/addr_cfg_if.sv
rtl/target_regs.sv
rtl/bus_monitor.sv
rtl/addr_receiver.sv
rtl/i3c_target_front.sv
tb/tb_clk_gen.sv
tb/tb_i3c_target_front.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status reflects the result
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f verilog.f --top-module tb_i3c_target_front -o sim_tb

# The simulation may stop with an error status; the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation PASSED" sim.log
